/* rtl/fetch_router.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module fetch_router (
  input  logic                    clk,
  input  logic                    rst,
  // cpu side
  input  logic                    fetch_req_valid_i,
  input  icache_pkg::fetch_req_t  fetch_req_i,
  output logic                    fetch_req_ready_o,
  output logic                    fetch_resp_valid_o,
  output icache_pkg::fetch_resp_t fetch_resp_o,
  input  logic                    fetch_resp_ready_i,
  // memory side
  output logic                    mem_req_valid_o,
  output icache_pkg::mem_req_t    mem_req_o,
  input  logic                    mem_req_ready_i,
  input  logic                    mem_beat_valid_i,
  output logic                    mem_beat_ready_o,
  // line store
  output logic                    ls_req_valid_o,
  output icache_pkg::fetch_req_t  ls_req_o,
  input  logic                    ls_req_ready_i,
  input  logic                    ls_resp_valid_i,
  input  icache_pkg::fetch_resp_t ls_resp_i,
  output logic                    ls_resp_ready_o,
  input  logic                    ls_mem_req_valid_i,
  input  icache_pkg::mem_req_t    ls_mem_req_i,
  output logic                    ls_mem_req_ready_o,
  output logic                    ls_beat_valid_o,
  input  logic                    ls_beat_ready_i,
  // uncached reader
  output logic                    uc_req_valid_o,
  output icache_pkg::fetch_req_t  uc_req_o,
  input  logic                    uc_req_ready_i,
  input  logic                    uc_resp_valid_i,
  input  icache_pkg::fetch_resp_t uc_resp_i,
  output logic                    uc_resp_ready_o,
  input  logic                    uc_mem_req_valid_i,
  input  icache_pkg::mem_req_t    uc_mem_req_i,
  output logic                    uc_mem_req_ready_o,
  output logic                    uc_beat_valid_o,
  input  logic                    uc_beat_ready_i
);

  // held low for the first cycle out of reset
  logic init_q;
  // one fetch in flight, owner_uc_q tells which side has it
  logic busy_q;
  logic owner_uc_q;

  logic is_uc;
  logic offer;
  logic ls_own;
  logic uc_own;

  // window decode on the incoming address
  assign is_uc = ((fetch_req_i.addr & `ICACHE_UNCACHED_MASK) == `ICACHE_UNCACHED_BASE);
  assign offer = fetch_req_valid_i && init_q && !busy_q;

  assign ls_own = busy_q && !owner_uc_q;
  assign uc_own = busy_q && owner_uc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      init_q     <= 1'b0;
      busy_q     <= 1'b0;
      owner_uc_q <= 1'b0;
    end else begin
      init_q <= 1'b1;
      if (fetch_req_valid_i && fetch_req_ready_o) begin
        busy_q     <= 1'b1;
        owner_uc_q <= is_uc;
      end else if (fetch_resp_valid_o && fetch_resp_ready_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // request steering
  assign ls_req_valid_o    = offer && !is_uc;
  assign uc_req_valid_o    = offer && is_uc;
  assign ls_req_o          = fetch_req_i;
  assign uc_req_o          = fetch_req_i;
  assign fetch_req_ready_o = init_q && !busy_q && (is_uc ? uc_req_ready_i : ls_req_ready_i);

  // response merge
  assign fetch_resp_valid_o = (ls_own && ls_resp_valid_i) || (uc_own && uc_resp_valid_i);
  assign fetch_resp_o       = owner_uc_q ? uc_resp_i : ls_resp_i;
  assign ls_resp_ready_o    = ls_own && fetch_resp_ready_i;
  assign uc_resp_ready_o    = uc_own && fetch_resp_ready_i;

  // memory port goes to the owner only
  assign mem_req_valid_o    = (ls_own && ls_mem_req_valid_i) || (uc_own && uc_mem_req_valid_i);
  assign mem_req_o          = owner_uc_q ? uc_mem_req_i : ls_mem_req_i;
  assign ls_mem_req_ready_o = ls_own && mem_req_ready_i;
  assign uc_mem_req_ready_o = uc_own && mem_req_ready_i;

  assign ls_beat_valid_o  = ls_own && mem_beat_valid_i;
  assign uc_beat_valid_o  = uc_own && mem_beat_valid_i;
  assign mem_beat_ready_o = (ls_own && ls_beat_ready_i) || (uc_own && uc_beat_ready_i);

endmodule

/* rtl/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// byte address width on both the fetch and the memory side
`define ICACHE_ADDR_BITS 32

// one memory beat, also one fetch response word
`define ICACHE_WORD_BITS 32

// line geometry
// 64 byte lines
`define ICACHE_OFFSET_BITS 6
// 128 lines, direct mapped
`define ICACHE_INDEX_BITS 7

// beats per line refill, 32-bit beats
`define ICACHE_LINE_WORDS 16

// uncached window
// address is uncached when (addr & mask) == base
`define ICACHE_UNCACHED_BASE 32'h1000_0000
`define ICACHE_UNCACHED_MASK 32'hF000_0000

`endif

/* rtl/icache_pkg.sv */
`include "icache_defs.svh"

package icache_pkg;

  // byte address, fetch and memory side
  typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;

  // memory beat or full instruction word
  typedef logic [`ICACHE_WORD_BITS-1:0] word_t;

  // one compressed instruction parcel
  typedef logic [`ICACHE_WORD_BITS/2-1:0] half_t;

  // address split: tag | index | offset
  typedef logic [`ICACHE_ADDR_BITS-`ICACHE_INDEX_BITS-`ICACHE_OFFSET_BITS-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

  // word position inside a line, also the refill beat count
  typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_t;

  // cpu fetch request
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  // fetch answer
  // is_wide set for a 32-bit encoding
  typedef struct packed {
    word_t data;
    logic  is_wide;
  } fetch_resp_t;

  // burst read request, len is beats minus one
  typedef struct packed {
    addr_t addr;
    beat_t len;
  } mem_req_t;

  // one read beat from memory
  typedef struct packed {
    word_t data;
    logic  last;
  } mem_beat_t;

  // line store control
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    RESPOND
  } refill_state_e;

endpackage

/* rtl/icache_top.sv */
`timescale 1ns/1ps

module icache_top (
  input  logic                    clk,
  input  logic                    rst,
  // cpu fetch request
  input  logic                    fetch_req_valid_i,
  input  icache_pkg::fetch_req_t  fetch_req_i,
  output logic                    fetch_req_ready_o,
  // cpu fetch response
  output logic                    fetch_resp_valid_o,
  output icache_pkg::fetch_resp_t fetch_resp_o,
  input  logic                    fetch_resp_ready_i,
  // memory read request
  output logic                    mem_req_valid_o,
  output icache_pkg::mem_req_t    mem_req_o,
  input  logic                    mem_req_ready_i,
  // memory read beats
  input  logic                    mem_beat_valid_i,
  input  icache_pkg::mem_beat_t   mem_beat_i,
  output logic                    mem_beat_ready_o
);

  import icache_pkg::*;

  // router <-> line store
  logic        ls_req_valid;
  fetch_req_t  ls_req;
  logic        ls_req_ready;
  logic        ls_resp_valid;
  fetch_resp_t ls_resp;
  logic        ls_resp_ready;
  logic        ls_mem_req_valid;
  mem_req_t    ls_mem_req;
  logic        ls_mem_req_ready;
  logic        ls_beat_valid;
  logic        ls_beat_ready;

  // router <-> uncached reader
  logic        uc_req_valid;
  fetch_req_t  uc_req;
  logic        uc_req_ready;
  logic        uc_resp_valid;
  fetch_resp_t uc_resp;
  logic        uc_resp_ready;
  logic        uc_mem_req_valid;
  mem_req_t    uc_mem_req;
  logic        uc_mem_req_ready;
  logic        uc_beat_valid;
  logic        uc_beat_ready;

  fetch_router u_fetch_router (
    .clk                (clk),
    .rst                (rst),
    .fetch_req_valid_i  (fetch_req_valid_i),
    .fetch_req_i        (fetch_req_i),
    .fetch_req_ready_o  (fetch_req_ready_o),
    .fetch_resp_valid_o (fetch_resp_valid_o),
    .fetch_resp_o       (fetch_resp_o),
    .fetch_resp_ready_i (fetch_resp_ready_i),
    .mem_req_valid_o    (mem_req_valid_o),
    .mem_req_o          (mem_req_o),
    .mem_req_ready_i    (mem_req_ready_i),
    .mem_beat_valid_i   (mem_beat_valid_i),
    .mem_beat_ready_o   (mem_beat_ready_o),
    .ls_req_valid_o     (ls_req_valid),
    .ls_req_o           (ls_req),
    .ls_req_ready_i     (ls_req_ready),
    .ls_resp_valid_i    (ls_resp_valid),
    .ls_resp_i          (ls_resp),
    .ls_resp_ready_o    (ls_resp_ready),
    .ls_mem_req_valid_i (ls_mem_req_valid),
    .ls_mem_req_i       (ls_mem_req),
    .ls_mem_req_ready_o (ls_mem_req_ready),
    .ls_beat_valid_o    (ls_beat_valid),
    .ls_beat_ready_i    (ls_beat_ready),
    .uc_req_valid_o     (uc_req_valid),
    .uc_req_o           (uc_req),
    .uc_req_ready_i     (uc_req_ready),
    .uc_resp_valid_i    (uc_resp_valid),
    .uc_resp_i          (uc_resp),
    .uc_resp_ready_o    (uc_resp_ready),
    .uc_mem_req_valid_i (uc_mem_req_valid),
    .uc_mem_req_i       (uc_mem_req),
    .uc_mem_req_ready_o (uc_mem_req_ready),
    .uc_beat_valid_o    (uc_beat_valid),
    .uc_beat_ready_i    (uc_beat_ready)
  );

  // beat payload goes straight to both sides, valid is routed
  line_store u_line_store (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (ls_req_valid),
    .req_i           (ls_req),
    .req_ready_o     (ls_req_ready),
    .resp_valid_o    (ls_resp_valid),
    .resp_o          (ls_resp),
    .resp_ready_i    (ls_resp_ready),
    .mem_req_valid_o (ls_mem_req_valid),
    .mem_req_o       (ls_mem_req),
    .mem_req_ready_i (ls_mem_req_ready),
    .beat_valid_i    (ls_beat_valid),
    .beat_i          (mem_beat_i),
    .beat_ready_o    (ls_beat_ready)
  );

  uncached_reader u_uncached_reader (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (uc_req_valid),
    .req_i           (uc_req),
    .req_ready_o     (uc_req_ready),
    .resp_valid_o    (uc_resp_valid),
    .resp_o          (uc_resp),
    .resp_ready_i    (uc_resp_ready),
    .mem_req_valid_o (uc_mem_req_valid),
    .mem_req_o       (uc_mem_req),
    .mem_req_ready_i (uc_mem_req_ready),
    .beat_valid_i    (uc_beat_valid),
    .beat_i          (mem_beat_i),
    .beat_ready_o    (uc_beat_ready)
  );

endmodule

/* rtl/line_store.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module line_store (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_valid_i,
  input  icache_pkg::fetch_req_t  req_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output icache_pkg::fetch_resp_t resp_o,
  input  logic                    resp_ready_i,
  output logic                    mem_req_valid_o,
  output icache_pkg::mem_req_t    mem_req_o,
  input  logic                    mem_req_ready_i,
  input  logic                    beat_valid_i,
  input  icache_pkg::mem_beat_t   beat_i,
  output logic                    beat_ready_o
);

  import icache_pkg::*;

  localparam int LINES    = 1 << `ICACHE_INDEX_BITS;
  localparam int OFF_BITS = `ICACHE_OFFSET_BITS;
  localparam int TAG_BITS = $bits(tag_t);

  refill_state_e state_q;

  // captured fetch address, held until the response is taken
  addr_t addr_q;

  // tag store and per-line valid bits
  tag_t                tag_mem [LINES];
  logic [LINES-1:0]    valid_q;

  // line data, one word per beat
  word_t data_mem [LINES][`ICACHE_LINE_WORDS];

  beat_t       beat_cnt_q;
  logic        mem_req_valid_q;
  fetch_resp_t resp_q;

  // fields of the captured address
  tag_t                  line_tag;
  index_t                line_idx;
  beat_t                 word_idx;
  beat_t                 next_idx;
  logic [OFF_BITS-2:0]   half_idx;

  logic  hit;
  logic  beat_fire;
  logic  last_beat;

  // the two words covering the instruction
  word_t rd_lo;
  word_t rd_hi;
  half_t first_half;
  half_t second_half;
  logic  last_half;
  fetch_resp_t extract;

  assign line_tag = addr_q[`ICACHE_ADDR_BITS-1 -: TAG_BITS];
  assign line_idx = addr_q[OFF_BITS +: `ICACHE_INDEX_BITS];
  assign word_idx = addr_q[OFF_BITS-1:2];
  assign half_idx = addr_q[OFF_BITS-1:1];
  assign next_idx = word_idx + 1'b1;

  assign hit       = valid_q[line_idx] && (tag_mem[line_idx] == line_tag);
  assign beat_fire = beat_valid_i && beat_ready_o;
  assign last_beat = beat_fire && beat_i.last;

  // forward the incoming beat so the answer is ready on the last beat
  always_comb begin
    rd_lo = data_mem[line_idx][word_idx];
    rd_hi = data_mem[line_idx][next_idx];
    if (state_q == REFILL && beat_cnt_q == word_idx) begin
      rd_lo = beat_i.data;
    end
    if (state_q == REFILL && beat_cnt_q == next_idx) begin
      rd_hi = beat_i.data;
    end
  end

  // compressed-aware extraction
  assign first_half  = addr_q[1] ? rd_lo[31:16] : rd_lo[15:0];
  assign second_half = addr_q[1] ? rd_hi[15:0] : rd_lo[31:16];
  // last parcel of the line, upper half is not fetched
  assign last_half   = &half_idx;

  always_comb begin
    extract.is_wide = (first_half[1:0] == 2'b11);
    if (extract.is_wide && !last_half) begin
      extract.data = {second_half, first_half};
    end else begin
      extract.data = {16'h0, first_half};
    end
  end

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= IDLE;
      valid_q         <= '0;
      beat_cnt_q      <= '0;
      mem_req_valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_valid_i) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit) begin
            state_q <= RESPOND;
          end else begin
            // miss, burst the whole line from its base
            state_q         <= REFILL;
            beat_cnt_q      <= '0;
            mem_req_valid_q <= 1'b1;
          end
        end
        REFILL: begin
          if (mem_req_valid_q && mem_req_ready_i) begin
            mem_req_valid_q <= 1'b0;
          end
          if (beat_fire) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
          end
          if (last_beat) begin
            valid_q[line_idx] <= 1'b1;
            state_q           <= RESPOND;
          end
        end
        RESPOND: begin
          if (resp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // payload: address, tags, data, response
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_valid_i) begin
      addr_q <= req_i.addr;
    end
    if ((state_q == LOOKUP && hit) || last_beat) begin
      resp_q <= extract;
    end
    if (last_beat) begin
      tag_mem[line_idx] <= line_tag;
    end
    if (beat_fire) begin
      data_mem[line_idx][beat_cnt_q] <= beat_i.data;
    end
  end

  assign req_ready_o  = (state_q == IDLE);
  assign resp_valid_o = (state_q == RESPOND);
  assign resp_o       = resp_q;
  // beats are always accepted while refilling
  assign beat_ready_o = (state_q == REFILL);

  assign mem_req_valid_o = mem_req_valid_q;
  assign mem_req_o.addr  = {addr_q[`ICACHE_ADDR_BITS-1:OFF_BITS], {OFF_BITS{1'b0}}};
  assign mem_req_o.len   = beat_t'(`ICACHE_LINE_WORDS - 1);

endmodule

/* rtl/uncached_reader.sv */
`timescale 1ns/1ps

module uncached_reader (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_valid_i,
  input  icache_pkg::fetch_req_t  req_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output icache_pkg::fetch_resp_t resp_o,
  input  logic                    resp_ready_i,
  output logic                    mem_req_valid_o,
  output icache_pkg::mem_req_t    mem_req_o,
  input  logic                    mem_req_ready_i,
  input  logic                    beat_valid_i,
  input  icache_pkg::mem_beat_t   beat_i,
  output logic                    beat_ready_o
);

  import icache_pkg::*;

  // word-aligned read address
  addr_t addr_q;
  word_t data_q;

  logic  mem_req_valid_q;
  // beat still outstanding
  logic  wait_beat_q;
  logic  resp_valid_q;

  logic  req_fire;
  logic  beat_fire;

  assign req_fire  = req_valid_i && req_ready_o;
  assign beat_fire = beat_valid_i && beat_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req_valid_q <= 1'b0;
      wait_beat_q     <= 1'b0;
      resp_valid_q    <= 1'b0;
    end else begin
      if (req_fire) begin
        mem_req_valid_q <= 1'b1;
        wait_beat_q     <= 1'b1;
      end else if (mem_req_valid_q && mem_req_ready_i) begin
        mem_req_valid_q <= 1'b0;
      end
      if (beat_fire) begin
        wait_beat_q  <= 1'b0;
        resp_valid_q <= 1'b1;
      end else if (resp_valid_q && resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      addr_q <= {req_i.addr[$bits(addr_t)-1:2], 2'b00};
    end
    if (beat_fire) begin
      data_q <= beat_i.data;
    end
  end

  // idle only when nothing is pending on either side
  assign req_ready_o  = !(wait_beat_q || resp_valid_q);
  assign beat_ready_o = wait_beat_q;

  assign mem_req_valid_o = mem_req_valid_q;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.len   = '0;

  // whole word returned, no width decode on this path
  assign resp_valid_o   = resp_valid_q;
  assign resp_o.data    = data_q;
  assign resp_o.is_wide = 1'b0;

endmodule

/* sim.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/line_store.sv
rtl/uncached_reader.sv
rtl/fetch_router.sv
rtl/icache_top.sv
tb/tb_mem_model.sv
tb/tb_icache.sv

/* tb/tb_icache.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module tb_icache;

  import icache_pkg::*;

  // 60 cycles for each of up to 30 fetch tests
  localparam int TIMEOUT_CYCLES = 30 * 60;
  localparam int WAIT_LIMIT     = 200;

  // two lines with the same index and different tags
  localparam addr_t LINE_A = 32'h0000_1040;
  localparam addr_t LINE_B = 32'h0000_3040;
  localparam addr_t UC_ADDR = `ICACHE_UNCACHED_BASE + 32'h0000_0206;

  logic        clk;
  logic        rst;
  logic        fetch_req_valid;
  fetch_req_t  fetch_req;
  logic        fetch_req_ready;
  logic        fetch_resp_valid;
  fetch_resp_t fetch_resp;
  logic        fetch_resp_ready;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_req_ready;
  logic        mem_beat_valid;
  mem_beat_t   mem_beat;
  logic        mem_beat_ready;

  int errors;
  int tests_run;
  int tests_failed;
  int cycles;

  icache_top i_dut (
    .clk                (clk),
    .rst                (rst),
    .fetch_req_valid_i  (fetch_req_valid),
    .fetch_req_i        (fetch_req),
    .fetch_req_ready_o  (fetch_req_ready),
    .fetch_resp_valid_o (fetch_resp_valid),
    .fetch_resp_o       (fetch_resp),
    .fetch_resp_ready_i (fetch_resp_ready),
    .mem_req_valid_o    (mem_req_valid),
    .mem_req_o          (mem_req),
    .mem_req_ready_i    (mem_req_ready),
    .mem_beat_valid_i   (mem_beat_valid),
    .mem_beat_i         (mem_beat),
    .mem_beat_ready_o   (mem_beat_ready)
  );

  tb_mem_model i_mem (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (mem_req_valid),
    .req_i        (mem_req),
    .req_ready_o  (mem_req_ready),
    .beat_valid_o (mem_beat_valid),
    .beat_o       (mem_beat),
    .beat_ready_i (mem_beat_ready)
  );

  always #50 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic half_t half_at(input addr_t a);
    word_t w;
    w = i_mem.mem[a[13:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // low bits 11 mark a 32-bit instruction
  // a wide one at the line end keeps only its first parcel
  function automatic fetch_resp_t expected_resp(input addr_t a);
    fetch_resp_t r;
    half_t       first;
    first     = half_at(a);
    r.is_wide = (first[1:0] == 2'b11);
    if (r.is_wide && a[5:1] != 5'h1f) begin
      r.data = {half_at(a + 2), first};
    end else begin
      r.data = {16'h0, first};
    end
    return r;
  endfunction

  // set the encoding bits of the parcel at a
  task automatic set_parcel_kind(input addr_t a, input logic [1:0] kind);
    word_t w;
    w = i_mem.mem[a[13:2]];
    if (a[1]) begin
      w[17:16] = kind;
    end else begin
      w[1:0] = kind;
    end
    i_mem.mem[a[13:2]] = w;
  endtask

  task automatic check_resp(input addr_t a, input fetch_resp_t got, input fetch_resp_t exp);
    if (got.data !== exp.data) begin
      $display("Mismatch fetch_resp.data at %h: got %h expected %h", a, got.data, exp.data);
      errors++;
    end
    if (got.is_wide !== exp.is_wide) begin
      $display("Mismatch fetch_resp.is_wide at %h: got %h expected %h", a, got.is_wide,
               exp.is_wide);
      errors++;
    end
  endtask

  task automatic check_mem_log(input int exp_count, input addr_t exp_addr, input beat_t exp_len);
    if (i_mem.req_count != exp_count) begin
      $display("Mismatch mem_req count: got %h expected %h", i_mem.req_count, exp_count);
      errors++;
    end
    if (i_mem.last_addr !== exp_addr) begin
      $display("Mismatch mem_req.addr: got %h expected %h", i_mem.last_addr, exp_addr);
      errors++;
    end
    if (i_mem.last_len !== exp_len) begin
      $display("Mismatch mem_req.len: got %h expected %h", i_mem.last_len, exp_len);
      errors++;
    end
  endtask

  // ends 5 ns after the edge that took the request
  task automatic send_request(input addr_t a, output bit ok);
    int waited;
    waited          = 0;
    fetch_req.addr  = a;
    fetch_req_valid = 1'b1;
    @(negedge clk);
    while (!fetch_req_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    ok = fetch_req_ready;
    if (!ok) begin
      $display("fetch request at %h was never accepted", a);
      errors++;
    end
    @(posedge clk);
    #5;
    fetch_req_valid = 1'b0;
  endtask

  // ends on the falling edge where the response is seen
  task automatic wait_response(input addr_t a, output fetch_resp_t resp, output bit ok);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!fetch_resp_valid && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    ok   = fetch_resp_valid;
    resp = fetch_resp;
    if (!ok) begin
      $display("no response arrived for fetch at %h", a);
      errors++;
    end
  endtask

  task automatic do_fetch(input addr_t a, output fetch_resp_t resp);
    bit ok;
    resp = '0;
    send_request(a, ok);
    if (ok) begin
      wait_response(a, resp, ok);
    end
    @(posedge clk);
    #5;
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    @(negedge clk);
    if (fetch_req_ready !== 1'b0) begin
      $display("Mismatch fetch_req_ready: got %h expected 0", fetch_req_ready);
      errors++;
    end
    if (fetch_resp_valid !== 1'b0) begin
      $display("Mismatch fetch_resp_valid: got %h expected 0", fetch_resp_valid);
      errors++;
    end
    if (mem_req_valid !== 1'b0) begin
      $display("Mismatch mem_req_valid: got %h expected 0", mem_req_valid);
      errors++;
    end
    if (mem_beat_ready !== 1'b0) begin
      $display("Mismatch mem_beat_ready: got %h expected 0", mem_beat_ready);
      errors++;
    end
    @(negedge clk);
    if (fetch_req_ready !== 1'b1) begin
      $display("Mismatch fetch_req_ready: got %h expected 1", fetch_req_ready);
      errors++;
    end
    @(posedge clk);
    #5;
    close_test("reset_state", e0);
  endtask

  task automatic test_cold_miss();
    int          e0;
    int          n0;
    fetch_resp_t exp;
    fetch_resp_t got;
    e0  = errors;
    n0  = i_mem.req_count;
    exp = expected_resp(LINE_A + 4);
    do_fetch(LINE_A + 4, got);
    check_resp(LINE_A + 4, got, exp);
    check_mem_log(n0 + 1, LINE_A, beat_t'(`ICACHE_LINE_WORDS - 1));
    close_test("cold_miss", e0);
  endtask

  task automatic test_hit_no_refetch();
    int          e0;
    int          n0;
    addr_t       offs [4];
    fetch_resp_t exp [4];
    word_t       saved [16];
    fetch_resp_t got;
    e0      = errors;
    n0      = i_mem.req_count;
    offs[0] = LINE_A + 8;
    offs[1] = LINE_A + 14;
    offs[2] = LINE_A + 20;
    offs[3] = LINE_A + 34;
    for (int k = 0; k < 4; k++) begin
      exp[k] = expected_resp(offs[k]);
    end
    // memory changes under the cached line
    for (int k = 0; k < 16; k++) begin
      saved[k] = i_mem.mem[LINE_A[13:2] + k];
      i_mem.mem[LINE_A[13:2] + k] = ~saved[k];
    end
    for (int k = 0; k < 4; k++) begin
      do_fetch(offs[k], got);
      check_resp(offs[k], got, exp[k]);
    end
    if (i_mem.req_count != n0) begin
      $display("Mismatch mem_req count: got %h expected %h", i_mem.req_count, n0);
      errors++;
    end
    for (int k = 0; k < 16; k++) begin
      i_mem.mem[LINE_A[13:2] + k] = saved[k];
    end
    close_test("hit_no_refetch", e0);
  endtask

  task automatic test_line_end_wide();
    int          e0;
    int          n0;
    fetch_resp_t exp;
    fetch_resp_t got;
    e0  = errors;
    n0  = i_mem.req_count;
    exp = expected_resp(LINE_A + 62);
    do_fetch(LINE_A + 62, got);
    check_resp(LINE_A + 62, got, exp);
    if (i_mem.req_count != n0) begin
      $display("Mismatch mem_req count: got %h expected %h", i_mem.req_count, n0);
      errors++;
    end
    close_test("line_end_wide", e0);
  endtask

  task automatic test_uncached();
    int          e0;
    int          n0;
    fetch_resp_t exp;
    fetch_resp_t got;
    e0          = errors;
    n0          = i_mem.req_count;
    exp.data    = i_mem.mem[UC_ADDR[13:2]];
    exp.is_wide = 1'b0;
    do_fetch(UC_ADDR, got);
    check_resp(UC_ADDR, got, exp);
    check_mem_log(n0 + 1, {UC_ADDR[31:2], 2'b00}, '0);
    // a second read must see the new word
    i_mem.mem[UC_ADDR[13:2]] = exp.data ^ 32'h5a5a_a5a5;
    exp.data = i_mem.mem[UC_ADDR[13:2]];
    do_fetch(UC_ADDR, got);
    check_resp(UC_ADDR, got, exp);
    check_mem_log(n0 + 2, {UC_ADDR[31:2], 2'b00}, '0);
    close_test("uncached", e0);
  endtask

  task automatic test_conflict();
    int          e0;
    int          n0;
    fetch_resp_t exp;
    fetch_resp_t got;
    e0  = errors;
    n0  = i_mem.req_count;
    exp = expected_resp(LINE_B + 4);
    do_fetch(LINE_B + 4, got);
    check_resp(LINE_B + 4, got, exp);
    check_mem_log(n0 + 1, LINE_B, beat_t'(`ICACHE_LINE_WORDS - 1));
    // line A was evicted
    exp = expected_resp(LINE_A + 4);
    do_fetch(LINE_A + 4, got);
    check_resp(LINE_A + 4, got, exp);
    check_mem_log(n0 + 2, LINE_A, beat_t'(`ICACHE_LINE_WORDS - 1));
    close_test("conflict", e0);
  endtask

  task automatic test_back_pressure();
    int          e0;
    fetch_resp_t exp;
    fetch_resp_t got;
    bit          ok;
    e0               = errors;
    exp              = expected_resp(LINE_A + 8);
    fetch_resp_ready = 1'b0;
    send_request(LINE_A + 8, ok);
    if (ok) begin
      wait_response(LINE_A + 8, got, ok);
    end
    if (ok) begin
      check_resp(LINE_A + 8, got, exp);
      repeat (4) begin
        @(negedge clk);
        if (fetch_resp_valid !== 1'b1) begin
          $display("Mismatch fetch_resp_valid: got %h expected 1", fetch_resp_valid);
          errors++;
        end
        if (fetch_resp !== exp) begin
          $display("Mismatch fetch_resp: got %h expected %h", fetch_resp, exp);
          errors++;
        end
        if (fetch_req_ready !== 1'b0) begin
          $display("Mismatch fetch_req_ready: got %h expected 0", fetch_req_ready);
          errors++;
        end
      end
    end
    @(posedge clk);
    #5;
    fetch_resp_ready = 1'b1;
    @(negedge clk);
    @(negedge clk);
    if (fetch_resp_valid !== 1'b0) begin
      $display("Mismatch fetch_resp_valid: got %h expected 0", fetch_resp_valid);
      errors++;
    end
    if (fetch_req_ready !== 1'b1) begin
      $display("Mismatch fetch_req_ready: got %h expected 1", fetch_req_ready);
      errors++;
    end
    @(posedge clk);
    #5;
    close_test("back_pressure", e0);
  endtask

  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    fetch_req_valid  = 1'b0;
    fetch_req        = '0;
    fetch_resp_ready = 1'b1;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    cycles           = 0;
    // fixed encodings on top of the random fill
    #1;
    set_parcel_kind(LINE_A + 4, 2'b01);
    set_parcel_kind(LINE_A + 8, 2'b11);
    set_parcel_kind(LINE_A + 14, 2'b11);
    set_parcel_kind(LINE_A + 62, 2'b11);
    set_parcel_kind(LINE_B + 4, 2'b10);
    set_parcel_kind(UC_ADDR, 2'b11);
    repeat (4) @(posedge clk);
    #5;
    rst = 1'b0;
    test_reset_state();
    test_cold_miss();
    test_hit_no_refetch();
    test_line_end_wide();
    test_uncached();
    test_conflict();
    test_back_pressure();
    $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid_i,
  input  icache_pkg::mem_req_t  req_i,
  output logic                  req_ready_o,
  output logic                  beat_valid_o,
  output icache_pkg::mem_beat_t beat_o,
  input  logic                  beat_ready_i
);

  import icache_pkg::*;

  localparam int DEPTH = 4096;

  // word array, indexed by address bits 13:2, rewritten by the tb
  word_t mem [DEPTH];

  logic [31:0] rnd_q;
  logic        stall_q;
  logic        busy_q;
  // beat offered but not yet taken
  logic        held_q;
  logic [11:0] word_q;
  beat_t       cnt_q;
  beat_t       len_q;

  // request log read by the tb
  int    req_count;
  addr_t last_addr;
  beat_t last_len;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    logic [31:0] r;
    r = 32'h52f7;
    for (int i = 0; i < DEPTH; i++) begin
      r = xorshift32(r);
      mem[i] = r;
    end
    rnd_q     = r;
    stall_q   = 1'b0;
    busy_q    = 1'b0;
    held_q    = 1'b0;
    word_q    = '0;
    cnt_q     = '0;
    len_q     = '0;
    req_count = 0;
    last_addr = '0;
    last_len  = '0;
  end

  // about one cycle in three is a stall
  assign req_ready_o  = !busy_q && !stall_q;
  // a beat once offered stays until taken
  assign beat_valid_o = busy_q && (!stall_q || held_q);
  assign beat_o.data  = mem[word_q];
  assign beat_o.last  = (cnt_q == len_q);

  always @(posedge clk) begin
    rnd_q   <= xorshift32(rnd_q);
    stall_q <= (rnd_q % 3) == 0;
    if (rst) begin
      busy_q <= 1'b0;
      held_q <= 1'b0;
    end else begin
      held_q <= beat_valid_o && !beat_ready_i;
      if (req_valid_i && req_ready_o) begin
        busy_q    <= 1'b1;
        word_q    <= req_i.addr[13:2];
        cnt_q     <= '0;
        len_q     <= req_i.len;
        req_count <= req_count + 1;
        last_addr <= req_i.addr;
        last_len  <= req_i.len;
      end else if (beat_valid_o && beat_ready_i) begin
        word_q <= word_q + 1'b1;
        cnt_q  <= cnt_q + 1'b1;
        if (beat_o.last) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

endmodule
